// File: filelist.f
+incdir+.
cache_pkg.sv
cache_control.sv
cache_datapath.sv
cache_top.sv
cache_checker.sv
cache_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= cache_tb
BUILD_DIR ?= obj_dir
FILELIST ?= filelist.f
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	! grep -q "TEST FAILED" $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: cache_tb.sv
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_tb;
	import cache_pkg::*;

	localparam int OPS_TOTAL = 4 * `CACHE_SETS + 16 + 4 + 500; // Sum over the five tests
	localparam int MISS_CYCLES = 32; // Worst-case dirty miss incl. both pmem waits
	localparam time TIMEOUT = (OPS_TOTAL * MISS_CYCLES + 40) * 20ns;

	logic clk;
	logic rst_n;
	logic mem_read;
	logic mem_write;
	logic [`CACHE_ADDR_W-1:0] mem_addr;
	word_t mem_wdata;
	logic mem_resp;
	word_t mem_rdata;
	logic pmem_resp;
	line_t pmem_rdata;
	logic pmem_read;
	logic pmem_write;
	logic [`CACHE_ADDR_W-1:0] pmem_addr;
	line_t pmem_wdata;

	logic [31:0] lfsr_state;
	int errors;
	int checks;

	// Reference cache, way first
	bit m_valid [2][`CACHE_SETS];
	bit m_dirty [2][`CACHE_SETS];
	tag_t m_tag [2][`CACHE_SETS];
	line_t m_data [2][`CACHE_SETS];
	bit m_lru [`CACHE_SETS];
	line_t mem [logic [`CACHE_ADDR_W-1:0]]; // Sparse backing store

	cache_top UUT (.*);

	always #10 clk = ~clk;

	initial begin
		#(TIMEOUT);
		$display("Watchdog expired, the cache stopped answering");
		$display("TEST FAILED");
		$finish;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
		end
		return r;
	endfunction

	function automatic line_t mem_line(input logic [`CACHE_ADDR_W-1:0] line_addr);
		line_t l;
		if (mem.exists(line_addr))
			return mem[line_addr];
		for (int w = 0; w < `CACHE_LINE_WORDS; w++)
			l[w] = ((line_addr | (w << 2)) * 32'h9e37_79b1) ^ 32'hc3a5_0f1e;
		return l;
	endfunction

	task automatic report_error(input string msg);
		errors++;
		$display("Error at %0t ns: %s", $time, msg);
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_line(input string name, input line_t got, input line_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input logic [`CACHE_ADDR_W-1:0] got,
		input logic [`CACHE_ADDR_W-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	////////////////////////////////////////////////////////////
	// One CPU access, with the memory model answering
	////////////////////////////////////////////////////////////

	task automatic run_op(input bit is_write, input logic [`CACHE_ADDR_W-1:0] addr,
		input word_t wdata);
		addr_fields_t f;
		addr_fields_t wb_f;
		logic [`CACHE_ADDR_W-1:0] line_addr;
		int way;
		int word_i;
		bit exp_hit;
		bit exp_wb;
		bit saw_rd;
		bit saw_wb;
		bit busy;
		bit done;
		bit resp_next;
		bit resp_rd;
		int wait_cnt;
		int cycles;
		line_t wb_line;
		line_t rd_line;
		f = addr_fields_t'(addr);
		line_addr = {addr[`CACHE_ADDR_W-1:`CACHE_OFFSET_W], {`CACHE_OFFSET_W{1'b0}}};
		word_i = f.offset >> `CACHE_BYTE_OFF_W;
		exp_hit = 0;
		way = m_lru[f.index];
		for (int w = 0; w < 2; w++) begin
			if (m_valid[w][f.index] && m_tag[w][f.index] == f.tag) begin
				exp_hit = 1;
				way = w;
			end
		end
		exp_wb = !exp_hit && m_valid[way][f.index] && m_dirty[way][f.index];
		wb_f.tag = m_tag[way][f.index];
		wb_f.index = f.index;
		wb_f.offset = '0;
		wb_line = m_data[way][f.index];
		rd_line = '0;
		saw_rd = 0;
		saw_wb = 0;
		busy = 0;
		done = 0;
		resp_next = 0;
		resp_rd = 0;
		wait_cnt = 0;
		cycles = 0;
		@(posedge clk);
		mem_read <= !is_write;
		mem_write <= is_write;
		mem_addr <= addr;
		mem_wdata <= wdata;
		while (!done) begin
			@(negedge clk);
			cycles++;
			resp_next = 0;
			resp_rd = 0;
			if (mem_resp) begin
				done = 1;
			end else if (pmem_resp) begin
				busy = 0; // Strobe seen this cycle, not a new request
			end else if (pmem_read || pmem_write) begin
				if (pmem_read && pmem_write)
					report_error("pmem_read and pmem_write both high");
				if (!busy) begin
					busy = 1;
					wait_cnt = rand_bits(3);
				end
				if (wait_cnt == 0) begin
					resp_next = 1;
					if (pmem_write) begin
						saw_wb = 1;
						check_addr("pmem_addr", pmem_addr, wb_f);
						check_line("pmem_wdata", pmem_wdata, wb_line);
						mem[pmem_addr] = pmem_wdata;
					end else begin
						saw_rd = 1;
						resp_rd = 1;
						check_addr("pmem_addr", pmem_addr, line_addr);
						rd_line = mem_line(pmem_addr);
					end
				end else begin
					wait_cnt--;
				end
			end
			if (!done) begin
				@(posedge clk);
				pmem_resp <= resp_next;
				if (resp_rd)
					pmem_rdata <= rd_line;
			end
		end
		if (!exp_hit) begin
			m_data[way][f.index] = mem_line(line_addr);
			m_tag[way][f.index] = f.tag;
			m_valid[way][f.index] = 1;
			m_dirty[way][f.index] = 0;
		end
		if (is_write) begin
			m_data[way][f.index][word_i] = wdata;
			m_dirty[way][f.index] = 1;
		end else begin
			check_word("mem_rdata", mem_rdata, m_data[way][f.index][word_i]);
		end
		m_lru[f.index] = (way == 0); // Other way becomes LRU
		if (exp_hit && cycles != 2)
			report_error($sformatf("hit took %0d cycles instead of one", cycles - 1));
		if (exp_hit && (saw_rd || saw_wb))
			report_error("memory traffic on a hit");
		if (!exp_hit && !saw_rd)
			report_error("miss finished without a line refill");
		if (exp_wb != saw_wb)
			report_error(exp_wb ? "dirty victim was not written back" : "unexpected writeback");
	endtask

	task automatic end_test(input string name, input int errors_before);
		if (errors == errors_before)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, errors - errors_before);
	endtask

	function automatic logic [`CACHE_ADDR_W-1:0] make_addr(input int tag, input int index,
		input int word);
		return (tag << (`CACHE_OFFSET_W + `CACHE_INDEX_W)) | (index << `CACHE_OFFSET_W)
			| (word << `CACHE_BYTE_OFF_W);
	endfunction

	initial begin
		int e0;
		logic [`CACHE_ADDR_W-1:0] a;
		clk = 0;
		rst_n = 0;
		mem_read = 0;
		mem_write = 0;
		mem_addr = '0;
		mem_wdata = '0;
		pmem_resp = 0;
		pmem_rdata = '0;
		lfsr_state = 32'h49e2_ecfb;
		errors = 0;
		checks = 0;
		for (int s = 0; s < `CACHE_SETS; s++) begin
			m_lru[s] = 0;
			for (int w = 0; w < 2; w++) begin
				m_valid[w][s] = 0;
				m_dirty[w][s] = 0;
			end
		end
		repeat (10) @(posedge clk);
		rst_n <= 1;

		e0 = errors; // Cold misses, both ways of every set
		for (int i = 0; i < 2 * `CACHE_SETS; i++)
			run_op(0, make_addr(i / `CACHE_SETS, i % `CACHE_SETS, i % 8), '0);
		end_test("cold misses", e0);

		e0 = errors;
		for (int i = 0; i < 2 * `CACHE_SETS; i++)
			run_op(0, make_addr(i / `CACHE_SETS, i % `CACHE_SETS, 7 - i % 8), '0);
		end_test("read hits", e0);

		e0 = errors;
		for (int i = 0; i < 8; i++) begin
			a = make_addr(i % 2, i, rand_bits(3));
			run_op(1, a, rand_bits(32));
			run_op(0, a, '0);
		end
		end_test("write then read", e0);

		e0 = errors;
		run_op(1, make_addr(5, 3, 2), 32'h1234_5678);
		run_op(1, make_addr(6, 3, 4), 32'h9abc_def0);
		run_op(0, make_addr(7, 3, 0), '0);
		run_op(0, make_addr(5, 3, 2), '0);
		end_test("eviction", e0);

		e0 = errors;
		for (int i = 0; i < 500; i++) begin
			a = make_addr(rand_bits(2), rand_bits(3), rand_bits(3));
			run_op(rand_bits(1) != 0, a, rand_bits(32));
		end
		end_test("random mix", e0);

		@(posedge clk);
		mem_read <= 0;
		mem_write <= 0;
		@(posedge clk);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule : cache_tb

// File: cache_checker.sv
`timescale 1ns/1ps

module cache_checker (
	input logic clk,
	input logic rst_n,
	input logic mem_read,
	input logic mem_write,
	input logic mem_resp,
	input logic pmem_read,
	input logic pmem_write,
	input logic pmem_resp,
	input cache_pkg::cache_cw_t cache_cw
);
	import cache_pkg::*;

	////////////////////////////////////////////////////////////
	// Memory port
	////////////////////////////////////////////////////////////

	pmem_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(pmem_read && pmem_write))
		else $error("pmem_read and pmem_write high together");

	pmem_read_held: assert property (@(posedge clk) disable iff (!rst_n)
		(pmem_read && !pmem_resp) |=> pmem_read)
		else $error("pmem_read dropped before pmem_resp");

	////////////////////////////////////////////////////////////
	// CPU port
	////////////////////////////////////////////////////////////

	// Response goes to the request that was captured
	resp_needs_request: assert property (@(posedge clk) disable iff (!rst_n)
		mem_resp |-> ((mem_read || mem_write)
			&& mem_read == cache_cw.mem_read && mem_write == cache_cw.mem_write))
		else $error("mem_resp without the held CPU request");

	quiet_after_reset: assert property (@(posedge clk)
		$rose(rst_n) |-> (!mem_resp && !pmem_read && !pmem_write))
		else $error("Outputs active in the cycle after reset");

endmodule : cache_checker

bind cache_control cache_checker checker_i (.*);

// File: cache_top.sv
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_top (
	input logic clk,
	input logic rst_n,
	// CPU port
	input logic mem_read,
	input logic mem_write,
	input logic [`CACHE_ADDR_W-1:0] mem_addr,
	input logic [`CACHE_DATA_W-1:0] mem_wdata,
	output logic mem_resp,
	output logic [`CACHE_DATA_W-1:0] mem_rdata,
	// Physical memory port
	input logic pmem_resp,
	input cache_pkg::line_t pmem_rdata,
	output logic pmem_read,
	output logic pmem_write,
	output logic [`CACHE_ADDR_W-1:0] pmem_addr,
	output cache_pkg::line_t pmem_wdata
);
	import cache_pkg::*;

	// Datapath status
	logic hit;
	logic tag0_hit;
	logic tag1_hit;
	logic dirty_ctrl;
	logic lru_out;
	cache_cw_t cache_cw;

	// Array strobes
	logic [1:0] load_data;
	logic [1:0] load_tag;
	logic set_valid0, set_valid1;
	logic set_dirty0, set_dirty1;
	logic clear_dirty0, clear_dirty1;
	logic load_lru;
	logic read_data;
	logic load_pipeline;

	cache_control control (
		.clk(clk), .rst_n(rst_n), .mem_read(mem_read), .mem_write(mem_write),
		.pmem_resp(pmem_resp), .hit(hit), .dirty_ctrl(dirty_ctrl), .lru_out(lru_out),
		.tag0_hit(tag0_hit), .tag1_hit(tag1_hit), .cache_cw(cache_cw),
		.pmem_read(pmem_read), .pmem_write(pmem_write), .mem_resp(mem_resp),
		.set_dirty0(set_dirty0), .set_dirty1(set_dirty1),
		.clear_dirty0(clear_dirty0), .clear_dirty1(clear_dirty1),
		.load_data(load_data), .load_tag(load_tag),
		.set_valid0(set_valid0), .set_valid1(set_valid1),
		.load_lru(load_lru), .read_data(read_data), .load_pipeline(load_pipeline)
	);

	cache_datapath datapath (
		.clk(clk), .rst_n(rst_n), .mem_read(mem_read), .mem_write(mem_write),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.load_data(load_data), .load_tag(load_tag),
		.set_valid0(set_valid0), .set_valid1(set_valid1),
		.set_dirty0(set_dirty0), .set_dirty1(set_dirty1),
		.clear_dirty0(clear_dirty0), .clear_dirty1(clear_dirty1),
		.load_lru(load_lru), .read_data(read_data), .load_pipeline(load_pipeline),
		.pmem_rdata(pmem_rdata), .hit(hit), .tag0_hit(tag0_hit), .tag1_hit(tag1_hit),
		.dirty_ctrl(dirty_ctrl), .lru_out(lru_out), .cache_cw(cache_cw),
		.mem_rdata(mem_rdata), .pmem_addr(pmem_addr), .pmem_wdata(pmem_wdata)
	);

endmodule : cache_top

// File: cache_datapath.sv
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_datapath (
	input logic clk,
	input logic rst_n,
	input logic mem_read,
	input logic mem_write,
	input logic [`CACHE_ADDR_W-1:0] mem_addr,
	input logic [`CACHE_DATA_W-1:0] mem_wdata,
	input logic [1:0] load_data,
	input logic [1:0] load_tag,
	input logic set_valid0,
	input logic set_valid1,
	input logic set_dirty0,
	input logic set_dirty1,
	input logic clear_dirty0,
	input logic clear_dirty1,
	input logic load_lru,
	input logic read_data,
	input logic load_pipeline,
	input cache_pkg::line_t pmem_rdata,
	output logic hit,
	output logic tag0_hit,
	output logic tag1_hit,
	output logic dirty_ctrl,
	output logic lru_out,
	output cache_pkg::cache_cw_t cache_cw,
	output logic [`CACHE_DATA_W-1:0] mem_rdata,
	output logic [`CACHE_ADDR_W-1:0] pmem_addr,
	output cache_pkg::line_t pmem_wdata
);
	import cache_pkg::*;

	// Way is the first index everywhere
	tag_t tag_arr [2][`CACHE_SETS];
	line_t data_arr [2][`CACHE_SETS];
	logic [1:0][`CACHE_SETS-1:0] valid_arr;
	logic [1:0][`CACHE_SETS-1:0] dirty_arr;
	logic [`CACHE_SETS-1:0] lru_arr; // 1 means way 1 is the victim

	addr_fields_t new_req;
	addr_fields_t req;
	addr_fields_t victim_fields;
	addr_fields_t line_fields;
	logic [`CACHE_WORD_IDX_W-1:0] word_sel;
	logic [1:0] way_hit;
	logic [1:0] set_valid;
	logic [1:0] set_dirty;
	logic [1:0] clear_dirty;
	logic victim;
	line_t hit_line;
	line_t line_in [2];

	function automatic line_t merge_word(
		input line_t line,
		input logic [`CACHE_WORD_IDX_W-1:0] sel,
		input word_t wdata
	);
		line_t merged;
		merged = line;
		merged[sel] = wdata;
		return merged;
	endfunction

	assign set_valid = {set_valid1, set_valid0};
	assign set_dirty = {set_dirty1, set_dirty0};
	assign clear_dirty = {clear_dirty1, clear_dirty0};

	////////////////////////////////////////////////////////////
	// Stage register
	////////////////////////////////////////////////////////////

	assign new_req = addr_fields_t'(mem_addr);

	always_ff @(posedge clk) begin
		if (load_pipeline && read_data) begin
			cache_cw.mem_read <= mem_read;
			cache_cw.mem_write <= mem_write;
			cache_cw.addr <= mem_addr;
			cache_cw.wdata <= mem_wdata;
			cache_cw.lru_out <= lru_arr[new_req.index];
		end
	end

	assign req = addr_fields_t'(cache_cw.addr);
	assign word_sel = req.offset[`CACHE_OFFSET_W-1:`CACHE_BYTE_OFF_W];
	assign victim = cache_cw.lru_out;

	////////////////////////////////////////////////////////////
	// Lookup
	////////////////////////////////////////////////////////////

	always_comb begin
		for (int w = 0; w < 2; w++) begin
			way_hit[w] = valid_arr[w][req.index] && (tag_arr[w][req.index] == req.tag);
		end
	end

	assign tag0_hit = way_hit[0];
	assign tag1_hit = way_hit[1];
	assign hit = |way_hit;
	assign lru_out = lru_arr[req.index];
	assign dirty_ctrl = valid_arr[victim][req.index] & dirty_arr[victim][req.index];

	assign hit_line = way_hit[1] ? data_arr[1][req.index] : data_arr[0][req.index];
	assign mem_rdata = hit_line[word_sel];

	// Refill takes the memory line, a write hit merges one word
	always_comb begin
		for (int w = 0; w < 2; w++) begin
			if (load_tag[w])
				line_in[w] = pmem_rdata;
			else
				line_in[w] = merge_word(data_arr[w][req.index], word_sel, cache_cw.wdata);
		end
	end

	always_comb begin
		victim_fields.tag = tag_arr[victim][req.index];
		victim_fields.index = req.index;
		victim_fields.offset = '0;
		line_fields.tag = req.tag;
		line_fields.index = req.index;
		line_fields.offset = '0;
	end

	// Writeback address while the victim's dirty bit is being cleared
	assign pmem_addr = (|clear_dirty) ? victim_fields : line_fields;
	assign pmem_wdata = data_arr[victim][req.index];

	////////////////////////////////////////////////////////////
	// Array updates
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		for (int w = 0; w < 2; w++) begin
			if (load_data[w])
				data_arr[w][req.index] <= line_in[w];
			if (load_tag[w])
				tag_arr[w][req.index] <= req.tag;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_arr <= '0;
			dirty_arr <= '0;
			lru_arr <= '0;
		end else begin
			for (int w = 0; w < 2; w++) begin
				if (set_valid[w])
					valid_arr[w][req.index] <= 1'b1;
				if (set_dirty[w])
					dirty_arr[w][req.index] <= 1'b1;
				else if (clear_dirty[w])
					dirty_arr[w][req.index] <= 1'b0;
			end
			if (load_lru)
				lru_arr[req.index] <= way_hit[0]; // Other way becomes LRU
		end
	end

endmodule : cache_datapath

// File: cache_control.sv
`timescale 1ns/1ps

module cache_control (
	input logic clk,
	input logic rst_n,
	input logic mem_read,
	input logic mem_write,
	input logic pmem_resp,
	input logic hit,
	input logic dirty_ctrl,
	input logic lru_out,
	input logic tag0_hit,
	input logic tag1_hit,
	input cache_pkg::cache_cw_t cache_cw,
	output logic pmem_read,
	output logic pmem_write,
	output logic mem_resp,
	output logic set_dirty0,
	output logic set_dirty1,
	output logic clear_dirty0,
	output logic clear_dirty1,
	output logic [1:0] load_data,
	output logic [1:0] load_tag,
	output logic set_valid0,
	output logic set_valid1,
	output logic load_lru,
	output logic read_data,
	output logic load_pipeline
);
	import cache_pkg::*;

	ctrl_state_e state;
	ctrl_state_e next_state;

	always_ff @(posedge clk) begin
		if (!rst_n)
			state <= idle;
		else
			state <= next_state;
	end

	////////////////////////////////////////////////////////////
	// Next state
	////////////////////////////////////////////////////////////

	always_comb begin
		next_state = state;
		unique case (state)
			idle: begin
				if (mem_read | mem_write)
					next_state = hit_detection;
			end
			hit_detection: begin
				if (hit)
					next_state = idle;
				else if (dirty_ctrl)
					next_state = store; // Victim must go out first
				else
					next_state = load;
			end
			store: begin
				if (pmem_resp)
					next_state = load;
			end
			load: begin
				if (pmem_resp)
					next_state = write_data;
			end
			write_data: begin
				// Replay the held request, it hits now
				next_state = hit_detection;
			end
			default: next_state = idle;
		endcase
	end

	////////////////////////////////////////////////////////////
	// State actions
	////////////////////////////////////////////////////////////

	always_comb begin
		load_lru = 1'b0;
		read_data = 1'b0;
		load_data = 2'b00;
		load_tag = 2'b00;
		set_valid0 = 1'b0;
		set_valid1 = 1'b0;
		set_dirty0 = 1'b0;
		set_dirty1 = 1'b0;
		clear_dirty0 = 1'b0;
		clear_dirty1 = 1'b0;
		mem_resp = 1'b0;
		pmem_read = 1'b0;
		pmem_write = 1'b0;
		load_pipeline = 1'b1;

		unique case (state)
			idle: begin
				read_data = mem_read | mem_write; // Capture request into stage reg
			end
			hit_detection: begin
				if (hit) begin
					load_lru = 1'b1;
					mem_resp = 1'b1;
					if (cache_cw.mem_write) begin
						load_data = {tag1_hit, tag0_hit};
						set_dirty0 = tag0_hit;
						set_dirty1 = tag1_hit;
					end
				end else begin
					load_pipeline = 1'b0; // Hold request through the miss
				end
			end
			store: begin
				load_pipeline = 1'b0;
				pmem_write = 1'b1;
				clear_dirty0 = ~lru_out;
				clear_dirty1 = lru_out;
			end
			load: begin
				load_pipeline = 1'b0;
				pmem_read = 1'b1;
				if (pmem_resp) begin
					load_data = {lru_out, ~lru_out};
					load_tag = {lru_out, ~lru_out};
					set_valid0 = ~lru_out;
					set_valid1 = lru_out;
				end
			end
			write_data: begin
				load_pipeline = 1'b0;
			end
			default: begin
				load_pipeline = 1'b1;
			end
		endcase
	end

endmodule : cache_control

// File: cache_pkg.sv
`include "cache_settings.svh"

package cache_pkg;

	////////////////////////////////////////////////////////////
	// Controller
	////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		idle,
		hit_detection,
		load, // Line refill from pmem
		store, // Victim writeback to pmem
		write_data
	} ctrl_state_e;

	////////////////////////////////////////////////////////////
	// Address and line types
	////////////////////////////////////////////////////////////

	typedef logic [`CACHE_TAG_W-1:0] tag_t;
	typedef logic [`CACHE_INDEX_W-1:0] index_t;
	typedef logic [`CACHE_OFFSET_W-1:0] offset_t; // Byte offset in line

	typedef logic [`CACHE_DATA_W-1:0] word_t;
	typedef word_t [`CACHE_LINE_WORDS-1:0] line_t; // Word 0 in the low bits

	typedef struct packed {
		tag_t tag;
		index_t index;
		offset_t offset;
	} addr_fields_t;

	// Request as captured at array read
	typedef struct packed {
		logic mem_read;
		logic mem_write;
		logic [`CACHE_ADDR_W-1:0] addr;
		word_t wdata;
		logic lru_out; // Victim way
	} cache_cw_t;

endpackage

// File: cache_settings.svh
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

////////////////////////////////////////////////////////////
// Cache geometry
////////////////////////////////////////////////////////////

`define CACHE_ADDR_W 32 // Byte address
`define CACHE_DATA_W 32 // CPU word
`define CACHE_LINE_WORDS 8
`define CACHE_SETS 8 // Per way

// Address field widths, all derived from the above
`define CACHE_BYTE_OFF_W $clog2(`CACHE_DATA_W / 8)
`define CACHE_WORD_IDX_W $clog2(`CACHE_LINE_WORDS)
`define CACHE_OFFSET_W (`CACHE_BYTE_OFF_W + `CACHE_WORD_IDX_W)
`define CACHE_INDEX_W $clog2(`CACHE_SETS)
`define CACHE_TAG_W (`CACHE_ADDR_W - `CACHE_INDEX_W - `CACHE_OFFSET_W)

`endif
